// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = rv_core_tb
FILELIST = rv_core_top.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: logic/core_pkg.sv
// shared widths, ALU operation codes and pipeline payload records for the integer core

package core_pkg;

    parameter int XLEN       = 32;  // data and address width
    parameter int REG_ADDR_W = 5;   // register index width
    parameter int NUM_REGS   = 32;  // architectural registers, x0 included

    // zero encoding is NONE so a cleared record carries no operation
    typedef enum logic [3:0] {
        ALU_NONE = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_AND  = 4'd3,
        ALU_OR   = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_LUI  = 4'd9,
        ALU_BEQ  = 4'd10,
        ALU_BNE  = 4'd11
    } alu_op_e;

    // decode to execute
    typedef struct packed {
        logic                  valid;     // slot holds an instruction
        logic                  illegal;   // unsupported encoding
        logic [XLEN-1:0]       pc;
        alu_op_e               op;
        logic [REG_ADDR_W-1:0] rs1_addr;
        logic                  rs1_re;    // rs1 read in use
        logic [REG_ADDR_W-1:0] rs2_addr;
        logic                  rs2_re;    // rs2 read in use
        logic                  use_imm;   // operand b from imm
        logic [XLEN-1:0]       imm;       // sign extended
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_we;     // never set for x0
    } id_ex_t;

    // execute to result
    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_we;
        logic [XLEN-1:0]       data;      // alu result or branch outcome
    } ex_wb_t;

endpackage

// File: logic/exu_execute.sv
// execute stage with operand read, forwarding from the result stage, ALU and branch resolve
`timescale 1ns/1ps

module exu_execute (
    input  core_pkg::id_ex_t                 id_ex_i,
    input  core_pkg::ex_wb_t                 ex_wb_fwd_i,  // record in the result stage
    input  logic                             hold_i,
    output logic [core_pkg::REG_ADDR_W-1:0]  rs1_addr_o,
    output logic [core_pkg::REG_ADDR_W-1:0]  rs2_addr_o,
    input  logic [core_pkg::XLEN-1:0]        rs1_data_i,
    input  logic [core_pkg::XLEN-1:0]        rs2_data_i,
    output core_pkg::ex_wb_t                 ex_wb_o,
    output logic                             flush_o,      // kill the word in decode
    output logic                             redirect_valid_o,
    output logic [core_pkg::XLEN-1:0]        redirect_pc_o
);

    import core_pkg::*;

    logic            fwd_rs1;
    logic            fwd_rs2;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic            eq;
    logic            taken;

    assign rs1_addr_o = id_ex_i.rs1_addr;
    assign rs2_addr_o = id_ex_i.rs2_addr;

    // rd_we is never set for x0, so no separate zero check
    assign fwd_rs1 = ex_wb_fwd_i.valid && ex_wb_fwd_i.rd_we && id_ex_i.rs1_re
                     && (ex_wb_fwd_i.rd == id_ex_i.rs1_addr);
    assign fwd_rs2 = ex_wb_fwd_i.valid && ex_wb_fwd_i.rd_we && id_ex_i.rs2_re
                     && (ex_wb_fwd_i.rd == id_ex_i.rs2_addr);

    assign rs1_val = fwd_rs1 ? ex_wb_fwd_i.data : rs1_data_i;
    assign rs2_val = fwd_rs2 ? ex_wb_fwd_i.data : rs2_data_i;

    assign op_a = rs1_val;
    assign op_b = id_ex_i.use_imm ? id_ex_i.imm : rs2_val;  // imm forms and LUI

    assign eq = (op_a == op_b);

    always_comb begin
        case (id_ex_i.op)
            ALU_ADD: alu_res = op_a + op_b;
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLL: alu_res = op_a << op_b[4:0];  // shamt is low 5 bits
            ALU_SRL: alu_res = op_a >> op_b[4:0];
            ALU_LUI: alu_res = op_b;
            ALU_BEQ: alu_res = XLEN'(eq);  // branch outcome as data
            ALU_BNE: alu_res = XLEN'(!eq);
            default: alu_res = '0;
        endcase
    end

    assign taken = id_ex_i.valid
                   && (((id_ex_i.op == ALU_BEQ) && eq) || ((id_ex_i.op == ALU_BNE) && !eq));

    // branch target, pc relative
    assign flush_o          = taken;
    assign redirect_valid_o = taken && !hold_i;  // one pulse per accepted cycle
    assign redirect_pc_o    = id_ex_i.pc + id_ex_i.imm;

    always_comb begin
        ex_wb_o         = '0;
        ex_wb_o.valid   = id_ex_i.valid;
        ex_wb_o.illegal = id_ex_i.illegal;
        ex_wb_o.pc      = id_ex_i.pc;
        ex_wb_o.rd      = id_ex_i.rd;
        ex_wb_o.rd_we   = id_ex_i.rd_we;  // low for branches
        ex_wb_o.data    = alu_res;
    end

endmodule

// File: logic/idu_decode.sv
// combinational RV32I subset decoder feeding the decode pipeline register
`timescale 1ns/1ps

module idu_decode (
    input  logic                      inst_valid_i,  // fetch offers a word
    input  logic [core_pkg::XLEN-1:0] inst_i,
    input  logic [core_pkg::XLEN-1:0] inst_addr_i,
    output core_pkg::id_ex_t          dec_o
);

    import core_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_u;
    logic [XLEN-1:0]       imm_b;
    alu_op_e               op;
    logic                  legal;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  use_imm;
    logic                  use_rd;
    logic [XLEN-1:0]       imm;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    // format and operation select
    always_comb begin
        op      = ALU_NONE;
        legal   = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_imm = 1'b0;
        use_rd  = 1'b0;
        imm     = '0;
        case (opcode)
            OPC_OP: begin
                legal   = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                use_rd  = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: op = ALU_ADD;
                    {7'b0100000, 3'b000}: op = ALU_SUB;
                    {7'b0000000, 3'b111}: op = ALU_AND;
                    {7'b0000000, 3'b110}: op = ALU_OR;
                    {7'b0000000, 3'b100}: op = ALU_XOR;
                    {7'b0000000, 3'b010}: op = ALU_SLT;
                    {7'b0000000, 3'b001}: op = ALU_SLL;
                    {7'b0000000, 3'b101}: op = ALU_SRL;
                    default:              legal = 1'b0;  // includes SRA, SLTU
                endcase
            end
            OPC_OP_IMM: begin
                legal   = 1'b1;
                use_rs1 = 1'b1;
                use_imm = 1'b1;
                use_rd  = 1'b1;
                imm     = imm_i;
                case (funct3)
                    3'b000:  op = ALU_ADD;
                    3'b111:  op = ALU_AND;
                    3'b110:  op = ALU_OR;
                    3'b100:  op = ALU_XOR;
                    3'b010:  op = ALU_SLT;
                    3'b001: begin
                        op    = ALU_SLL;
                        legal = (funct7 == 7'b0000000);
                    end
                    3'b101: begin
                        op    = ALU_SRL;
                        legal = (funct7 == 7'b0000000);  // SRAI not kept
                    end
                    default: legal = 1'b0;
                endcase
            end
            OPC_LUI: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                use_rd  = 1'b1;
                imm     = imm_u;
                op      = ALU_LUI;
            end
            OPC_BRANCH: begin
                legal   = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm     = imm_b;
                case (funct3)
                    3'b000:  op = ALU_BEQ;
                    3'b001:  op = ALU_BNE;
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
    end

    // illegal words keep only valid, illegal and pc
    always_comb begin
        dec_o = '0;
        if (inst_valid_i) begin
            dec_o.valid   = 1'b1;
            dec_o.illegal = !legal;
            dec_o.pc      = inst_addr_i;
            if (legal) begin
                dec_o.op       = op;
                dec_o.rs1_addr = use_rs1 ? inst_i[19:15] : '0;
                dec_o.rs1_re   = use_rs1;
                dec_o.rs2_addr = use_rs2 ? inst_i[24:20] : '0;
                dec_o.rs2_re   = use_rs2;
                dec_o.use_imm  = use_imm;
                dec_o.imm      = imm;
                dec_o.rd_we    = use_rd && (rd != '0);  // x0 never written
                dec_o.rd       = dec_o.rd_we ? rd : '0;
            end
        end
    end

endmodule

// File: logic/rv_core_top.sv
// top level of the in-order RV32I subset pipeline, fed by an external fetch source
`timescale 1ns/1ps

module rv_core_top (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            inst_valid_i,
    input  logic [core_pkg::XLEN-1:0]       inst_i,
    input  logic [core_pkg::XLEN-1:0]       inst_addr_i,
    input  logic                            hold_i,            // stalls every stage
    output logic                            retire_valid_o,
    output logic [core_pkg::XLEN-1:0]       retire_pc_o,
    output logic [core_pkg::REG_ADDR_W-1:0] retire_rd_o,
    output logic [core_pkg::XLEN-1:0]       retire_data_o,
    output logic                            retire_illegal_o,
    output logic                            redirect_valid_o,
    output logic [core_pkg::XLEN-1:0]       redirect_pc_o
);

    import core_pkg::*;

    id_ex_t                dec;
    id_ex_t                id_ex_q;
    ex_wb_t                ex_wb_d;
    ex_wb_t                ex_wb_q;
    logic                  ex_flush;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    idu_decode u_decode (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .dec_o        (dec)
    );

    stage_pipe #(.payload_t(id_ex_t)) u_id_ex (
        .clk     (clk),
        .reset_i (reset_i),
        .hold_i  (hold_i),
        .flush_i (ex_flush),  // taken branch drops the word behind it
        .d_i     (dec),
        .q_o     (id_ex_q)
    );

    exu_execute u_execute (
        .id_ex_i          (id_ex_q),
        .ex_wb_fwd_i      (ex_wb_q),
        .hold_i           (hold_i),
        .rs1_addr_o       (rs1_addr),
        .rs2_addr_o       (rs2_addr),
        .rs1_data_i       (rs1_data),
        .rs2_data_i       (rs2_data),
        .ex_wb_o          (ex_wb_d),
        .flush_o          (ex_flush),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    stage_pipe #(.payload_t(ex_wb_t)) u_ex_wb (
        .clk     (clk),
        .reset_i (reset_i),
        .hold_i  (hold_i),
        .flush_i (1'b0),  // nothing kills a resolved instruction
        .d_i     (ex_wb_d),
        .q_o     (ex_wb_q)
    );

    wbu_result u_result (
        .clk              (clk),
        .reset_i          (reset_i),
        .hold_i           (hold_i),
        .ex_wb_i          (ex_wb_q),
        .rs1_addr_i       (rs1_addr),
        .rs2_addr_i       (rs2_addr),
        .rs1_data_o       (rs1_data),
        .rs2_data_o       (rs2_data),
        .retire_valid_o   (retire_valid_o),
        .retire_pc_o      (retire_pc_o),
        .retire_rd_o      (retire_rd_o),
        .retire_data_o    (retire_data_o),
        .retire_illegal_o (retire_illegal_o)
    );

endmodule

// File: logic/stage_pipe.sv
// stall and flush pipeline register, one instance per stage boundary with its own record type
`timescale 1ns/1ps

module stage_pipe #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     hold_i,   // keep current record
    input  logic     flush_i,  // load an empty record
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t d_next;

    // a flushed slot is all zero, so valid and every enable drop together
    assign d_next = flush_i ? payload_t'('0) : d_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            q_o <= '0;
        end else if (!hold_i) begin
            q_o <= d_next;
        end
    end

endmodule

// File: logic/wbu_result.sv
// result stage holding the register file, its write port and the retire report
`timescale 1ns/1ps

module wbu_result (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            hold_i,
    input  core_pkg::ex_wb_t                ex_wb_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [core_pkg::XLEN-1:0]       rs1_data_o,
    output logic [core_pkg::XLEN-1:0]       rs2_data_o,
    output logic                            retire_valid_o,
    output logic [core_pkg::XLEN-1:0]       retire_pc_o,
    output logic [core_pkg::REG_ADDR_W-1:0] retire_rd_o,
    output logic [core_pkg::XLEN-1:0]       retire_data_o,
    output logic                            retire_illegal_o
);

    import core_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];  // entry 0 is never written
    logic            wr_sel;
    logic            wr_en;

    // record asks for a write
    assign wr_sel = ex_wb_i.valid && ex_wb_i.rd_we && (ex_wb_i.rd != '0);
    assign wr_en  = wr_sel && !hold_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[ex_wb_i.rd] <= ex_wb_i.data;
        end
    end

    // x0 reads zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    // Retire reports the record sitting in the result register. Its write lands at
    // the edge that ends this cycle, so the report and the register file agree.
    assign retire_valid_o   = ex_wb_i.valid && !hold_i;
    assign retire_pc_o      = ex_wb_i.pc;
    assign retire_rd_o      = wr_sel ? ex_wb_i.rd : '0;  // zero when nothing written
    assign retire_data_o    = ex_wb_i.data;
    assign retire_illegal_o = ex_wb_i.illegal;

endmodule

// File: rv_core_top.f
logic/core_pkg.sv
logic/idu_decode.sv
logic/stage_pipe.sv
logic/exu_execute.sv
logic/wbu_result.sv
logic/rv_core_top.sv
tb/rv_core_assertions.sv
tb/rv_core_tb.sv

// File: tb/rv_core_assertions.sv
// concurrent protocol checks on the core ports, attached to rv_core_top by bind
`timescale 1ns/1ps

module rv_core_assertions (
    input logic       clk,
    input logic       reset_i,
    input logic       hold_i,
    input logic       retire_valid_i,
    input logic       retire_illegal_i,
    input logic [4:0] retire_rd_i,
    input logic       redirect_valid_i
);

    int assert_errs = 0;

    // a held pipeline reports nothing
    a_hold_quiet: assert property (@(posedge clk) disable iff (reset_i)
        hold_i |-> (!retire_valid_i && !redirect_valid_i))
        else begin
            assert_errs++;
            $error("retire or redirect active while hold_i is high");
        end

    // both pipeline registers empty after reset
    a_reset_quiet: assert property (@(posedge clk)
        $fell(reset_i) |-> (!retire_valid_i && !redirect_valid_i))
        else begin
            assert_errs++;
            $error("retire or redirect active right after reset");
        end

    a_illegal_rd: assert property (@(posedge clk) disable iff (reset_i)
        (retire_valid_i && retire_illegal_i) |-> (retire_rd_i == 5'd0))
        else begin
            assert_errs++;
            $error("illegal retire reports a nonzero rd");
        end

endmodule

bind rv_core_top rv_core_assertions u_assertions (
    .clk              (clk),
    .reset_i          (reset_i),
    .hold_i           (hold_i),
    .retire_valid_i   (retire_valid_o),
    .retire_illegal_i (retire_illegal_o),
    .retire_rd_i      (retire_rd_o),
    .redirect_valid_i (redirect_valid_o)
);

// File: tb/rv_core_tb.sv
// testbench acting as fetch source with random hold, checking retires against an ISA model
`timescale 1ns/1ps

module rv_core_tb;

    import core_pkg::*;

    localparam int NUM_INST   = 600;   // accepted words
    localparam int MAX_CYCLES = 5000;
    localparam int DRAIN_MAX  = 50;

    logic        clk;
    logic        reset_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic [31:0] inst_addr_i;
    logic        hold_i;
    logic        retire_valid_o;
    logic [31:0] retire_pc_o;
    logic [4:0]  retire_rd_o;
    logic [31:0] retire_data_o;
    logic        retire_illegal_o;
    logic        redirect_valid_o;
    logic [31:0] redirect_pc_o;

    integer      seed;
    int          value_errs;
    int          flow_errs;
    logic [31:0] mregs [32];           // model register file
    logic        drop_next;            // word after a taken branch is flushed
    logic        redir_seen;
    logic [31:0] redir_pc;
    logic [31:0] exp_pc_q [$];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_data_q [$];
    logic        exp_ill_q [$];
    logic [31:0] exp_tgt_q [$];

    rv_core_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] alu_ref(alu_op_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLT: return {31'b0, $signed(a) < $signed(b)};
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic [4:0] pick_reg();
        return 5'($unsigned($random(seed)) % 8);  // x0 to x7 with x0 now and then
    endfunction

    function automatic logic pick_hold();
        return ($unsigned($random(seed)) % 100) < 15;
    endfunction

    function automatic logic [31:0] gen_inst();
        int          kind;
        logic [2:0]  f3;
        logic [12:0] off;
        logic [31:0] w;
        kind = $unsigned($random(seed)) % 16;
        f3   = 3'($random(seed));
        if (kind < 5) begin  // R-type, SUB and the seven funct3 ops
            if ((kind == 0) && (f3 == 3'b011)) w = {7'b0100000, pick_reg(), pick_reg(), 3'b000,
                                                    pick_reg(), 7'b0110011};
            else w = {7'b0, pick_reg(), pick_reg(), (f3 == 3'b011) ? 3'b000 : f3,
                      pick_reg(), 7'b0110011};
        end else if (kind < 9) begin
            if (f3 == 3'b011) f3 = 3'b000;
            if ((f3 == 3'b001) || (f3 == 3'b101)) w = {7'b0, 5'($random(seed)), pick_reg(), f3,
                                                      pick_reg(), 7'b0010011};
            else w = {12'($random(seed)), pick_reg(), f3, pick_reg(), 7'b0010011};
        end else if (kind == 9) begin
            w = {20'($random(seed)), pick_reg(), 7'b0110111};
        end else if (kind < 13) begin
            off = 13'(((($random(seed)) & 7) - 3) * 8);  // short hops both ways
            w = {off[12], off[10:5], pick_reg(), pick_reg(), 2'b00, f3[0], off[4:1], off[11],
                 7'b1100011};
        end else if (kind == 13) begin
            w = {7'b0100000, pick_reg(), pick_reg(), 3'b101, pick_reg(), 7'b0110011};  // SRA
        end else if (kind == 14) begin
            w = {25'($random(seed)), 7'b0000011};  // load
        end else begin
            w = {7'b0, pick_reg(), pick_reg(), 3'b000, pick_reg(), 7'b0110011};
        end
        return w;
    endfunction

    // interpret one accepted word in program order
    task automatic model_accept(input logic [31:0] w, input logic [31:0] pc);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immi;
        logic [31:0] immb;
        logic [31:0] res;
        logic        ill;
        logic        we;
        logic        taken;
        rd    = w[11:7];
        f3    = w[14:12];
        f7    = w[31:25];
        a     = mregs[w[19:15]];
        b     = mregs[w[24:20]];
        immi  = {{20{w[31]}}, w[31:20]};
        immb  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        res   = 32'h0;
        ill   = 1'b0;
        we    = 1'b0;
        taken = 1'b0;
        case (w[6:0])
            7'b0110011: begin
                we = 1'b1;
                case ({f7, f3})
                    10'b0000000_000: res = alu_ref(ALU_ADD, a, b);
                    10'b0100000_000: res = alu_ref(ALU_SUB, a, b);
                    10'b0000000_111: res = alu_ref(ALU_AND, a, b);
                    10'b0000000_110: res = alu_ref(ALU_OR, a, b);
                    10'b0000000_100: res = alu_ref(ALU_XOR, a, b);
                    10'b0000000_010: res = alu_ref(ALU_SLT, a, b);
                    10'b0000000_001: res = alu_ref(ALU_SLL, a, b);
                    10'b0000000_101: res = alu_ref(ALU_SRL, a, b);
                    default:         ill = 1'b1;
                endcase
            end
            7'b0010011: begin
                we = 1'b1;
                case (f3)
                    3'b000:  res = alu_ref(ALU_ADD, a, immi);
                    3'b111:  res = alu_ref(ALU_AND, a, immi);
                    3'b110:  res = alu_ref(ALU_OR, a, immi);
                    3'b100:  res = alu_ref(ALU_XOR, a, immi);
                    3'b010:  res = alu_ref(ALU_SLT, a, immi);
                    3'b001:  res = alu_ref(ALU_SLL, a, immi);
                    3'b101:  res = alu_ref(ALU_SRL, a, immi);
                    default: ill = 1'b1;
                endcase
                if (((f3 == 3'b001) || (f3 == 3'b101)) && (f7 != 7'b0)) ill = 1'b1;
            end
            7'b0110111: begin
                we  = 1'b1;
                res = {w[31:12], 12'b0};
            end
            7'b1100011: begin
                if (f3 == 3'b000) taken = (a == b);
                else if (f3 == 3'b001) taken = (a != b);
                else ill = 1'b1;
                res = {31'b0, taken};
            end
            default: ill = 1'b1;
        endcase
        if (drop_next) begin
            drop_next = 1'b0;  // flushed by the branch ahead
        end else begin
            if (ill) begin
                we = 1'b0;
            end
            if (we && (rd != 5'd0)) mregs[rd] = res;
            exp_pc_q.push_back(pc);
            exp_rd_q.push_back((we && (rd != 5'd0)) ? rd : 5'd0);
            exp_data_q.push_back(res);
            exp_ill_q.push_back(ill);
            if (taken) begin
                exp_tgt_q.push_back(pc + immb);
                drop_next = 1'b1;
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    // outputs are stable mid cycle
    always @(negedge clk) begin
        logic ill;
        redir_seen = 1'b0;
        if (!reset_i && retire_valid_o) begin
            if (exp_pc_q.size() == 0) begin
                $display("retire seen with no instruction expected at pc %h", retire_pc_o);
                flow_errs++;
            end else begin
                ill = exp_ill_q.pop_front();
                check_value("retire_pc", exp_pc_q.pop_front(), retire_pc_o);
                check_value("retire_illegal", {31'b0, ill}, {31'b0, retire_illegal_o});
                check_value("retire_rd", {27'b0, exp_rd_q.pop_front()}, {27'b0, retire_rd_o});
                if (!ill) check_value("retire_data", exp_data_q.pop_front(), retire_data_o);
                else void'(exp_data_q.pop_front());
            end
        end
        if (!reset_i && redirect_valid_o) begin
            redir_seen = 1'b1;
            redir_pc   = redirect_pc_o;
            if (exp_tgt_q.size() == 0) begin
                $display("redirect seen with no taken branch expected");
                flow_errs++;
            end else begin
                check_value("redirect_pc", exp_tgt_q.pop_front(), redirect_pc_o);
            end
        end
    end

    initial begin
        int accepted;
        int cycles;
        int waited;
        int assert_errs;
        seed         = 32'h8a2a_3896;
        value_errs   = 0;
        flow_errs    = 0;
        drop_next    = 1'b0;
        redir_seen   = 1'b0;
        redir_pc     = 32'h0;
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = 32'h0;
        inst_addr_i  = 32'h0;
        hold_i       = 1'b0;
        for (int i = 0; i < 32; i++) mregs[i] = 32'h0;
        repeat (3) @(posedge clk);
        #2;
        reset_i      = 1'b0;
        inst_valid_i = 1'b1;
        inst_i       = gen_inst();
        hold_i       = pick_hold();
        accepted     = 0;
        cycles       = 0;
        while ((accepted < NUM_INST) && (cycles < MAX_CYCLES)) begin
            @(posedge clk);
            cycles++;
            if (inst_valid_i && !hold_i) begin
                accepted++;
                model_accept(inst_i, inst_addr_i);
                #2;
                inst_addr_i = redir_seen ? redir_pc : inst_addr_i + 32'd4;
                inst_i      = gen_inst();
            end else begin
                #2;  // held so the offer stays unchanged
            end
            hold_i = pick_hold();
        end
        if (accepted < NUM_INST) begin
            $display("timeout: only %0d words accepted", accepted);
            flow_errs++;
        end
        inst_valid_i = 1'b0;
        hold_i       = 1'b0;
        waited       = 0;
        while (((exp_pc_q.size() != 0) || (exp_tgt_q.size() != 0)) && (waited < DRAIN_MAX)) begin
            @(posedge clk);
            waited++;
        end
        if ((exp_pc_q.size() != 0) || (exp_tgt_q.size() != 0)) begin
            $display("timeout: %0d retires and %0d redirects never appeared",
                     exp_pc_q.size(), exp_tgt_q.size());
            flow_errs++;
        end
        @(posedge clk);
        assert_errs = u_dut.u_assertions.assert_errs;
        $display("errors: %0d value, %0d flow, %0d assertion", value_errs, flow_errs,
                 assert_errs);
        if ((value_errs == 0) && (flow_errs == 0) && (assert_errs == 0)) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
